// File: logic/fabric_defines.svh
`ifndef FABRIC_DEFINES_SVH
`define FABRIC_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// fabric sizing
////////////////////////////////////////////////////////////////////////////

// number of sources and also of destinations
`define FAB_PORTS 4

// width of one request word
`define FAB_WIDTH 16

// per-source queue depth
`define FAB_SRC_DEPTH 4

// shared queue depth between merge and split
// one slot of headroom is kept for the word held in the merge register
`define FAB_BUF_DEPTH 8

`endif

// File: logic/fabric_pkg.sv
package fabric_pkg;

  `include "fabric_defines.svh"

  //////////////////////////////////////////////////////////////////////////
  // shared vector types
  //////////////////////////////////////////////////////////////////////////

  // one request word as it moves through the fabric
  // the fabric never looks inside it
  typedef logic [`FAB_WIDTH-1:0] fab_word_t;

  // one bit per source or per destination
  // used for requests, grants, strobes and status levels
  typedef logic [`FAB_PORTS-1:0] port_mask_t;

  // index of a single port
  // wraps modulo the port count, which the round-robin pointer relies on
  typedef logic [$clog2(`FAB_PORTS)-1:0] port_idx_t;

endpackage

// File: logic/rr_grant.sv
`timescale 1ns/100ps
`include "fabric_defines.svh"

module rr_grant
  import fabric_pkg::*;
(
  input  logic       clock,
  input  logic       rstn,
  input  port_mask_t reqs,
  input  logic       advance,
  output port_mask_t grants
);

  ////////////////////////////////////////////////////////////////////////////
  // grant search
  ////////////////////////////////////////////////////////////////////////////

  // port with the highest priority this cycle
  port_idx_t prio_ptr;
  // port that won the search
  port_idx_t win_idx;
  logic      any_grant;

  // walk the ports starting at the pointer
  // first requester found wins
  always_comb begin
    port_idx_t cand;
    grants    = '0;
    win_idx   = prio_ptr;
    any_grant = 1'b0;
    for (int k = 0; k < `FAB_PORTS; k++) begin
      // index wraps since port_idx_t is exactly log2 of the port count
      cand = prio_ptr + port_idx_t'(k);
      if (!any_grant && reqs[cand]) begin
        grants[cand] = 1'b1;
        win_idx      = cand;
        any_grant    = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // priority rotation
  ////////////////////////////////////////////////////////////////////////////

  // port 0 first after reset
  // a used grant makes the winner the lowest priority next time
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      prio_ptr <= '0;
    end else if (advance && any_grant) begin
      prio_ptr <= win_idx + 1'b1;
    end
  end

  // at most one winner, and only a port that is asking
  a_grant_legal: assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(grants) && ((grants & ~reqs) == '0))
    else $error("rr_grant: grant %b does not fit requests %b", grants, reqs);

endmodule

// File: logic/word_fifo.sv
`timescale 1ns/100ps

module word_fifo
  import fabric_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic      clock,
  input  logic      rstn,
  input  logic      push,
  input  fab_word_t push_data,
  input  logic      pop,
  output fab_word_t head,
  output logic      empty,
  output logic      full,
  output logic      almost_full
);

  // pointer and occupancy widths
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  fab_word_t     mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // step a pointer around the ring
  // depth need not be a power of two
  function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
    if (ptr == PW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // status and show-ahead head
  ////////////////////////////////////////////////////////////////////////////

  // a push into a full queue is dropped
  assign do_push = push && !full;
  // a pop of an empty queue is dropped
  assign do_pop  = pop && !empty;

  assign empty       = (count == '0);
  assign full        = (count == CW'(DEPTH));
  // one slot kept back for a word already in flight
  assign almost_full = (count >= CW'(DEPTH - 1));
  // oldest word is always visible
  assign head        = mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // the producer must watch full
  a_no_overflow: assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
    else $error("word_fifo: push while full, word dropped");

  // the consumer must watch empty
  a_no_underflow: assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
    else $error("word_fifo: pop while empty");

endmodule

// File: logic/merge_arbiter.sv
`timescale 1ns/100ps
`include "fabric_defines.svh"

module merge_arbiter
  import fabric_pkg::*;
(
  input  logic       clock,
  input  logic       rstn,
  input  logic       enabled,
  input  port_mask_t requests,
  input  fab_word_t  buffer_in [`FAB_PORTS],
  output port_mask_t ready,
  output logic       merge_valid,
  output fab_word_t  merge_data
);

  port_mask_t grant;
  fab_word_t  win_word;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration among non-empty source queues
  ////////////////////////////////////////////////////////////////////////////

  // pointer only moves when the downstream queue can take the word
  rr_grant rr_inst (
    .clock   (clock),
    .rstn    (rstn),
    .reqs    (requests),
    .advance (enabled),
    .grants  (grant)
  );

  // pick the head word of the winning queue
  always_comb begin
    win_word = '0;
    for (int i = 0; i < `FAB_PORTS; i++) begin
      if (grant[i]) begin
        win_word = buffer_in[i];
      end
    end
  end

  // pop strobe back to the winner, same cycle
  assign ready = grant & {`FAB_PORTS{enabled}};

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  // valid follows a used grant by one cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      merge_valid <= 1'b0;
    end else begin
      merge_valid <= enabled && (|grant);
    end
  end

  // word register, zero when blocked
  always_ff @(posedge clock) begin
    if (enabled) begin
      merge_data <= win_word;
    end else begin
      merge_data <= '0;
    end
  end

  // blocked means no pop now and nothing pushed downstream next cycle
  a_blocked_quiet: assert property (@(posedge clock) disable iff (!rstn)
    !enabled |-> (ready == '0) ##1 !merge_valid)
    else $error("merge_arbiter: activity while disabled");

endmodule

// File: logic/split_arbiter.sv
`timescale 1ns/100ps
`include "fabric_defines.svh"

module split_arbiter
  import fabric_pkg::*;
(
  input  logic       clock,
  input  logic       rstn,
  input  logic       enabled,
  input  fab_word_t  buffer_in,
  input  port_mask_t requests,
  output logic       pop,
  output port_mask_t dst_valid,
  output fab_word_t  dst_data [`FAB_PORTS]
);

  port_mask_t grant;
  // grant that really moves a word this cycle
  port_mask_t take;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration among requesting destinations
  ////////////////////////////////////////////////////////////////////////////

  // rotates only when the shared queue has a word to give
  rr_grant rr_inst (
    .clock   (clock),
    .rstn    (rstn),
    .reqs    (requests),
    .advance (enabled),
    .grants  (grant)
  );

  assign take = grant & {`FAB_PORTS{enabled}};
  // shared queue head leaves as soon as someone takes it
  assign pop  = |take;

  ////////////////////////////////////////////////////////////////////////////
  // delivery registers
  ////////////////////////////////////////////////////////////////////////////

  // one-cycle valid pulse on the granted lane
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      dst_valid <= '0;
    end else begin
      dst_valid <= take;
    end
  end

  // word on the granted lane only
  // other lanes read zero
  always_ff @(posedge clock) begin
    for (int j = 0; j < `FAB_PORTS; j++) begin
      if (take[j]) begin
        dst_data[j] <= buffer_in;
      end else begin
        dst_data[j] <= '0;
      end
    end
  end

  // never more than one lane served
  a_one_lane: assert property (@(posedge clock) disable iff (!rstn) $onehot0(dst_valid))
    else $error("split_arbiter: dst_valid %b not one-hot", dst_valid);

endmodule

// File: logic/req_fabric_top.sv
`timescale 1ns/100ps
`include "fabric_defines.svh"

module req_fabric_top
  import fabric_pkg::*;
(
  input  logic       clock,
  input  logic       rstn,
  input  port_mask_t src_push,
  input  fab_word_t  src_data [`FAB_PORTS],
  output port_mask_t src_full,
  input  port_mask_t dst_request,
  output port_mask_t dst_valid,
  output fab_word_t  dst_data [`FAB_PORTS]
);

  ////////////////////////////////////////////////////////////////////////////
  // internal wiring
  ////////////////////////////////////////////////////////////////////////////

  // source queue status and heads
  port_mask_t src_empty;
  port_mask_t src_pop;
  fab_word_t  src_head [`FAB_PORTS];

  // merged stream into the shared queue
  logic       merge_valid;
  fab_word_t  merge_data;

  // shared queue toward the split side
  fab_word_t  buf_head;
  logic       buf_empty;
  logic       buf_almost_full;
  logic       buf_pop;

  ////////////////////////////////////////////////////////////////////////////
  // producer side
  ////////////////////////////////////////////////////////////////////////////

  // one queue per source
  // full goes straight back to the source
  for (genvar i = 0; i < `FAB_PORTS; i++) begin : g_src
    word_fifo #(
      .DEPTH (`FAB_SRC_DEPTH)
    ) src_fifo (
      .clock       (clock),
      .rstn        (rstn),
      .push        (src_push[i]),
      .push_data   (src_data[i]),
      .pop         (src_pop[i]),
      .head        (src_head[i]),
      .empty       (src_empty[i]),
      .full        (src_full[i]),
      .almost_full ()
    );
  end

  // non-empty queues compete
  // stalls once the shared queue is almost full
  merge_arbiter merge_inst (
    .clock       (clock),
    .rstn        (rstn),
    .enabled     (~buf_almost_full),
    .requests    (~src_empty),
    .buffer_in   (src_head),
    .ready       (src_pop),
    .merge_valid (merge_valid),
    .merge_data  (merge_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // shared buffer
  ////////////////////////////////////////////////////////////////////////////

  // full level is not needed here
  // almost_full already covers the word in the merge register
  word_fifo #(
    .DEPTH (`FAB_BUF_DEPTH)
  ) buf_fifo (
    .clock       (clock),
    .rstn        (rstn),
    .push        (merge_valid),
    .push_data   (merge_data),
    .pop         (buf_pop),
    .head        (buf_head),
    .empty       (buf_empty),
    .full        (),
    .almost_full (buf_almost_full)
  );

  ////////////////////////////////////////////////////////////////////////////
  // consumer side
  ////////////////////////////////////////////////////////////////////////////

  // hands the head word to one requesting destination
  split_arbiter split_inst (
    .clock     (clock),
    .rstn      (rstn),
    .enabled   (~buf_empty),
    .buffer_in (buf_head),
    .requests  (dst_request),
    .pop       (buf_pop),
    .dst_valid (dst_valid),
    .dst_data  (dst_data)
  );

endmodule

// File: sim/fabric_tests.svh
`ifndef FABRIC_TESTS_SVH
`define FABRIC_TESTS_SVH

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////

// quiet outputs before any traffic
task automatic check_reset();
  if (dst_valid != '0) flag_error($sformatf("dst_valid %b after reset", dst_valid));
  if (src_full != '0) flag_error($sformatf("src_full %b after reset", src_full));
endtask

// one word, source 2 to lane 1, three edges after the push edge
task automatic check_single_path();
  int push_edge;
  clear_log();
  dst_request = port_mask_t'(2);
  stage_push(2);
  push_edge = cycle + 1;
  step();
  clear_push();
  wait_drain("single path");
  if (dlv_lane.size() != 1) begin
    flag_error($sformatf("single path gave %0d deliveries", dlv_lane.size()));
  end else begin
    if (dlv_lane[0] != 1) flag_error($sformatf("word on lane %0d, not 1", dlv_lane[0]));
    if (dlv_cycle[0] - push_edge != 3) begin
      flag_error($sformatf("latency %0d cycles, expected 3", dlv_cycle[0] - push_edge));
    end
  end
  // winner plus one on both sides
  merge_ptr = 3;
  split_ptr = 2;
  dst_request = '0;
endtask

// all sources busy, ids come out in pointer rotation
task automatic check_merge_order();
  int exp_src;
  clear_log();
  dst_request = port_mask_t'(1);
  for (int n = 0; n < 4; n++) begin
    for (int s = 0; s < `FAB_PORTS; s++) stage_push(s);
    step();
  end
  clear_push();
  wait_drain("merge fairness");
  if (dlv_word.size() != 4 * `FAB_PORTS) flag_error("merge fairness lost words");
  for (int k = 0; k < dlv_word.size(); k++) begin
    exp_src = (merge_ptr + k) % `FAB_PORTS;
    if (int'(dlv_word[k][`FAB_WIDTH-1 -: 4]) != exp_src) begin
      flag_error($sformatf("merge slot %0d from source %0d, expected %0d",
                           k, dlv_word[k][`FAB_WIDTH-1 -: 4], exp_src));
    end
    if (dlv_lane[k] != 0) flag_error($sformatf("merge slot %0d on lane %0d", k, dlv_lane[k]));
  end
  // whole turns leave the merge pointer in place, lane 0 won every split grant
  split_ptr = 1;
  dst_request = '0;
endtask

// all lanes asking, lanes served in rotation
task automatic check_split_order();
  int exp_lane;
  clear_log();
  dst_request = '1;
  for (int n = 0; n < 2; n++) begin
    for (int s = 0; s < `FAB_PORTS; s++) stage_push(s);
    step();
  end
  clear_push();
  wait_drain("split fairness");
  if (dlv_lane.size() != 2 * `FAB_PORTS) flag_error("split fairness lost words");
  for (int k = 0; k < dlv_lane.size(); k++) begin
    exp_lane = (split_ptr + k) % `FAB_PORTS;
    if (dlv_lane[k] != exp_lane) begin
      flag_error($sformatf("split slot %0d on lane %0d, expected %0d", k, dlv_lane[k], exp_lane));
    end
  end
  split_ptr = (split_ptr + dlv_lane.size()) % `FAB_PORTS;
  dst_request = '0;
endtask

// fill everything with no consumer, then release
task automatic check_back_pressure();
  int accepted;
  int full_run;
  int n;
  clear_log();
  accepted = 0;
  full_run = 0;
  n = 0;
  // stalled once all sources read full twice in a row
  while (full_run < 2 && n < DRAIN_LIMIT) begin
    clear_push();
    for (int s = 0; s < `FAB_PORTS; s++) begin
      if (!src_full[s]) begin
        stage_push(s);
        accepted++;
      end
    end
    full_run = (src_full == '1) ? full_run + 1 : 0;
    step();
    n++;
  end
  clear_push();
  if (accepted != `FAB_PORTS * `FAB_SRC_DEPTH + `FAB_BUF_DEPTH) begin
    flag_error($sformatf("fabric took %0d words before stalling, expected %0d",
                         accepted, `FAB_PORTS * `FAB_SRC_DEPTH + `FAB_BUF_DEPTH));
  end
  if (dlv_lane.size() != 0) flag_error("delivery while no destination requested");
  dst_request = '1;
  wait_drain("back-pressure");
  if (dlv_lane.size() != accepted) flag_error("back-pressure delivery count wrong");
  dst_request = '0;
endtask

// random requests and pushes, collector checks order per source
task automatic check_random_order();
  logic [31:0] r;
  int          pushed;
  int          n;
  clear_log();
  pushed = 0;
  n = 0;
  while (pushed < RAND_WORDS && n < RAND_WORDS * 8) begin
    clear_push();
    r = lcg_next();
    dst_request = port_mask_t'(r >> 16);
    for (int s = 0; s < `FAB_PORTS; s++) begin
      if (!src_full[s] && r[24 + s] && pushed < RAND_WORDS) begin
        stage_push(s);
        pushed++;
      end
    end
    step();
    n++;
  end
  clear_push();
  dst_request = '1;
  wait_drain("random traffic");
  if (dlv_word.size() != pushed) begin
    flag_error($sformatf("%0d words pushed, %0d delivered", pushed, dlv_word.size()));
  end
  dst_request = '0;
endtask

`endif

// File: sim/fabric_tb.sv
`timescale 1ns/100ps
`include "fabric_defines.svh"

module fabric_tb
  import fabric_pkg::*;
();

  ////////////////////////////////////////////////////////////////////////////
  // run lengths, all in clock cycles
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD    = 10;
  localparam int RESET_CYCLES  = 8;
  localparam int RAND_WORDS    = 64;
  // longest wait for the fabric to empty
  localparam int DRAIN_LIMIT   = 200;
  // every test loop is bounded, so this sums the worst case
  localparam int TEST_CYCLES   = RESET_CYCLES + 6 * DRAIN_LIMIT + RAND_WORDS * 8 + 16;
  localparam int MARGIN_CYCLES = 500;
  localparam logic [31:0] SEED = 32'd49614;

  logic       clock;
  logic       rstn;
  port_mask_t src_push;
  fab_word_t  src_data [`FAB_PORTS];
  port_mask_t src_full;
  port_mask_t dst_request;
  port_mask_t dst_valid;
  fab_word_t  dst_data [`FAB_PORTS];

  // expected words per source, oldest first
  fab_word_t   exp_q [`FAB_PORTS][$];
  // deliveries seen by the collector
  int          dlv_lane [$];
  fab_word_t   dlv_word [$];
  int          dlv_cycle [$];
  int          cycle = 0;
  int          error_count;
  int          delivered;
  logic [31:0] lcg_state;
  // round-robin model pointers, port 0 first after reset
  int          merge_ptr;
  int          split_ptr;

  req_fabric_top uut (
    .clock       (clock),
    .rstn        (rstn),
    .src_push    (src_push),
    .src_data    (src_data),
    .src_full    (src_full),
    .dst_request (dst_request),
    .dst_valid   (dst_valid),
    .dst_data    (dst_data)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // edge count, read away from the rising edge
  always @(posedge clock) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // source id on top, random sequence bits below
  function automatic fab_word_t make_word(input int src);
    logic [31:0] seq;
    seq = lcg_next() >> 12;
    return {src[3:0], seq[`FAB_WIDTH-5:0]};
  endfunction

  function automatic int pending_words();
    int total;
    total = 0;
    for (int s = 0; s < `FAB_PORTS; s++) total += exp_q[s].size();
    return total;
  endfunction

  task automatic flag_error(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    error_count++;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clock);
    #1;
  endtask

  // word goes in on the next edge, scoreboard follows
  task automatic stage_push(input int src);
    fab_word_t w;
    w = make_word(src);
    src_push[src] = 1'b1;
    src_data[src] = w;
    exp_q[src].push_back(w);
  endtask

  task automatic clear_push();
    src_push = '0;
  endtask

  task automatic clear_log();
    dlv_lane.delete();
    dlv_word.delete();
    dlv_cycle.delete();
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while (pending_words() != 0 && n < DRAIN_LIMIT) begin
      step();
      n++;
    end
    if (pending_words() != 0) begin
      $display("%s timed out after %0d cycles with %0d words never delivered",
               what, n, pending_words());
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // delivery collector, samples at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin : collector
    int id;
    forever begin
      @(negedge clock);
      for (int j = 0; j < `FAB_PORTS; j++) begin
        if (rstn && dst_valid[j]) begin
          id = int'(dst_data[j][`FAB_WIDTH-1 -: 4]);
          dlv_lane.push_back(j);
          dlv_word.push_back(dst_data[j]);
          dlv_cycle.push_back(cycle);
          delivered++;
          // must be the oldest word still owed by that source
          if (id >= `FAB_PORTS || exp_q[id].size() == 0) begin
            flag_error($sformatf("lane %0d delivered unexpected word %h", j, dst_data[j]));
          end else begin
            if (dst_data[j] != exp_q[id][0]) begin
              flag_error($sformatf("lane %0d got %h, expected %h from source %0d",
                                   j, dst_data[j], exp_q[id][0], id));
            end
            void'(exp_q[id].pop_front());
          end
        end else if (rstn && dst_data[j] != '0) begin
          flag_error($sformatf("idle lane %0d shows %h", j, dst_data[j]));
        end
      end
    end
  end

  `include "fabric_tests.svh"

  initial begin : watchdog
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
    $display("run did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    rstn        = 1'b0;
    src_push    = '0;
    dst_request = '0;
    for (int s = 0; s < `FAB_PORTS; s++) src_data[s] = '0;
    lcg_state   = SEED;
    error_count = 0;
    delivered   = 0;
    merge_ptr   = 0;
    split_ptr   = 0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 rstn = 1'b1;
    step();
    check_reset();
    check_single_path();
    check_merge_order();
    check_split_order();
    check_back_pressure();
    check_random_order();
    $display("closing report: %0d errors, %0d words delivered", error_count, delivered);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+logic
+incdir+sim
logic/fabric_pkg.sv
logic/rr_grant.sv
logic/word_fifo.sv
logic/merge_arbiter.sv
logic/split_arbiter.sv
logic/req_fabric_top.sv
sim/fabric_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the request fabric testbench with verilator
# run from anywhere, paths are relative to the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fabric_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module fabric_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the result
if grep -q "^Test OK$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
